/* src/mulConfigPkg.sv */
package mulConfigPkg;

	// operand width the top level builds with
	// must stay even so that radix-4 mode can pair the multiplier bits
	localparam int defaultOperandWidth = 32;

	// codes of the mode input, sampled only when a multiply starts

	// one multiplier bit retired per step
	localparam logic modeRadix2 = 1'b0;

	// two multiplier bits retired per step
	localparam logic modeRadix4 = 1'b1;

endpackage

/* src/boothPkg.sv */
package boothPkg;

	// a Booth digit travels as three flags
	// zero flag set means no multiple is added at all
	// negate flag set means the multiple is subtracted
	// double flag set means twice the multiplicand is used
	// all flags clear is plain +1 times the multiplicand

	// bit position of the zero flag
	localparam int digitZero = 0;

	// bit position of the negate flag
	localparam int digitNegate = 1;

	// bit position of the double flag
	localparam int digitDouble = 2;

	// extra high bits in the partial-product half
	// needed so that -2 times the most negative multiplicand does not wrap
	localparam int guardBits = 2;

endpackage

/* src/mulControl.sv */
module mulControl #(
	parameter int operandWidth = 32
) (
	input  logic clk,
	input  logic rstN,
	input  logic enable,
	input  logic mode,
	output logic load,
	output logic step,
	output logic shiftTwo,
	output logic finish,
	output logic busy,
	output logic done
);

	// the counter only has to reach the index of the last step
	localparam int countWidth = $clog2(operandWidth);

	// index of the last step for each mode
	localparam logic [countWidth-1:0] lastRadix2 = countWidth'(operandWidth - 1);
	localparam logic [countWidth-1:0] lastRadix4 = countWidth'(operandWidth / 2 - 1);

	// FSM state codes
	localparam logic [1:0] stateIdle = 2'd0;
	localparam logic [1:0] stateRun = 2'd1;
	localparam logic [1:0] stateFinish = 2'd2;

	logic [1:0] state;
	logic [countWidth-1:0] stepCount;
	logic [countWidth-1:0] lastIndex;
	logic lastStep;

	// step limit follows the mode latched at start
	assign lastIndex = shiftTwo ? lastRadix4 : lastRadix2;
	assign lastStep = (stepCount == lastIndex);

	// operands are taken on the same edge that sees enable while idle
	assign load = (state == stateIdle) && enable;

	// one step per cycle while running
	assign step = (state == stateRun);

	// finish is the cycle right before the capture edge
	assign finish = (state == stateFinish);

	// an enable seen here is ignored
	assign busy = (state != stateIdle);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= stateIdle;
			stepCount <= '0;
			shiftTwo <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			// done is a single-cycle pulse
			done <= 1'b0;
			case (state)
				stateIdle:
				begin
					if (load)
					begin
						state <= stateRun;
						stepCount <= '0;
						case (mode)
							mulConfigPkg::modeRadix2:
								shiftTwo <= 1'b0;
							mulConfigPkg::modeRadix4:
								shiftTwo <= 1'b1;
						endcase
					end
				end
				stateRun:
				begin
					stepCount <= stepCount + countWidth'(1);
					if (lastStep)
					begin
						state <= stateFinish;
					end
				end
				stateFinish:
				begin
					// product is captured on this same edge
					done <= 1'b1;
					state <= stateIdle;
				end
				default:
				begin
					state <= stateIdle;
				end
			endcase
		end
	end

endmodule

/* src/boothRecoder.sv */
module boothRecoder (
	input  logic [2:0] lowBits,
	input  logic       shiftTwo,
	output logic [2:0] digit
);

	logic isZero;
	logic isNegate;
	logic isDouble;

	always_comb
	begin
		isZero = 1'b0;
		isNegate = 1'b0;
		isDouble = 1'b0;
		if (shiftTwo)
		begin
			// overlapping triplet of b[i+1], b[i], b[i-1]
			case (lowBits)
				3'b000,
				3'b111:
					{isZero, isNegate, isDouble} = 3'b100;
				3'b001,
				3'b010:
					{isZero, isNegate, isDouble} = 3'b000;
				3'b011:
					{isZero, isNegate, isDouble} = 3'b001;
				3'b100:
					{isZero, isNegate, isDouble} = 3'b011;
				3'b101,
				3'b110:
					{isZero, isNegate, isDouble} = 3'b010;
				default:
					{isZero, isNegate, isDouble} = 3'b100;
			endcase
		end
		else
		begin
			// current bit and the one below it, top bit of the triplet unused
			case (lowBits[1:0])
				2'b01:
					{isZero, isNegate, isDouble} = 3'b000;
				2'b10:
					{isZero, isNegate, isDouble} = 3'b010;
				default:
					{isZero, isNegate, isDouble} = 3'b100;
			endcase
		end
	end

	// pack the flags at their digit positions
	assign digit[boothPkg::digitZero] = isZero;
	assign digit[boothPkg::digitNegate] = isNegate;
	assign digit[boothPkg::digitDouble] = isDouble;

endmodule

/* src/boothAccumulator.sv */
module boothAccumulator #(
	parameter int operandWidth = 32
) (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           load,
	input  logic                           step,
	input  logic                           shiftTwo,
	input  logic [2:0]                     digit,
	input  logic signed [operandWidth-1:0] a,
	input  logic signed [operandWidth-1:0] b,
	output logic [2:0]                     lowBits,
	output logic [2*operandWidth-1:0]      accWord
);

	// high half carries the guard bits
	localparam int highWidth = operandWidth + boothPkg::guardBits;

	// high half, multiplier half and the extra bit below the multiplier
	localparam int regWidth = highWidth + operandWidth + 1;

	logic signed [operandWidth-1:0] multiplicand;
	logic signed [regWidth-1:0] accReg;
	logic signed [highWidth-1:0] highHalf;
	logic signed [highWidth-1:0] singleMult;
	logic signed [highWidth-1:0] multiple;
	logic signed [highWidth-1:0] partialSum;
	logic signed [regWidth-1:0] summed;

	assign highHalf = accReg[regWidth-1 -: highWidth];

	// multiplicand sign extended into the guard bits
	assign singleMult = {{boothPkg::guardBits{multiplicand[operandWidth-1]}}, multiplicand};

	// pick 0, 1x or 2x of the multiplicand
	always_comb
	begin
		if (digit[boothPkg::digitZero])
		begin
			multiple = '0;
		end
		else if (digit[boothPkg::digitDouble])
		begin
			multiple = singleMult <<< 1;
		end
		else
		begin
			multiple = singleMult;
		end
	end

	// add or subtract into the high half
	assign partialSum = digit[boothPkg::digitNegate] ? highHalf - multiple
		: highHalf + multiple;

	// register image after the add, before the shift
	assign summed = {partialSum, accReg[operandWidth:0]};

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			multiplicand <= '0;
			accReg <= '0;
		end
		else if (load)
		begin
			multiplicand <= a;
			// high half cleared, multiplier with a zero bit below it
			accReg <= {{highWidth{1'b0}}, b, 1'b0};
		end
		else if (step)
		begin
			// arithmetic shift keeps the partial product's sign
			accReg <= shiftTwo ? (summed >>> 2) : (summed >>> 1);
		end
	end

	// next multiplier bits for the recoder
	assign lowBits = accReg[2:0];

	// after the last shift the product sits just above the extra bit
	assign accWord = accReg[2*operandWidth:1];

endmodule

/* src/resultRegister.sv */
module resultRegister #(
	parameter int operandWidth = 32
) (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             finish,
	input  logic [2*operandWidth-1:0]        accWord,
	output logic signed [2*operandWidth-1:0] product,
	output logic                             overflow
);

	// upper half plus the sign bit of the lower word
	logic [operandWidth:0] upperBits;
	logic fitsWord;

	assign upperBits = accWord[2*operandWidth-1:operandWidth-1];

	// fits when every one of those bits agrees with the sign
	assign fitsWord = (&upperBits) || !(|upperBits);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			product <= '0;
			overflow <= 1'b0;
		end
		else if (finish)
		begin
			product <= $signed(accWord);
			overflow <= !fitsWord;
		end
	end

endmodule

/* src/boothMultiplier.sv */
module boothMultiplier #(
	parameter int operandWidth = mulConfigPkg::defaultOperandWidth
) (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             enable,
	input  logic                             mode,
	input  logic signed [operandWidth-1:0]   a,
	input  logic signed [operandWidth-1:0]   b,
	output logic signed [2*operandWidth-1:0] product,
	output logic                             overflow,
	output logic                             busy,
	output logic                             done
);

	// strobes from the controller
	logic load;
	logic step;
	logic shiftTwo;
	logic finish;

	// datapath wires
	logic [2:0] lowBits;
	logic [2:0] digit;
	logic [2*operandWidth-1:0] accWord;

	mulControl #(
		.operandWidth(operandWidth)
	) control0 (
		.clk(clk),
		.rstN(rstN),
		.enable(enable),
		.mode(mode),
		.load(load),
		.step(step),
		.shiftTwo(shiftTwo),
		.finish(finish),
		.busy(busy),
		.done(done)
	);

	// radix-2 or radix-4 digit from the low register bits
	boothRecoder recoder0 (
		.lowBits(lowBits),
		.shiftTwo(shiftTwo),
		.digit(digit)
	);

	boothAccumulator #(
		.operandWidth(operandWidth)
	) accumulator0 (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.step(step),
		.shiftTwo(shiftTwo),
		.digit(digit),
		.a(a),
		.b(b),
		.lowBits(lowBits),
		.accWord(accWord)
	);

	// product and overflow held until the next operation ends
	resultRegister #(
		.operandWidth(operandWidth)
	) result0 (
		.clk(clk),
		.rstN(rstN),
		.finish(finish),
		.accWord(accWord),
		.product(product),
		.overflow(overflow)
	);

endmodule

/* verif/boothMultiplierTb.sv */
module boothMultiplierTb;

	localparam int operandWidth = mulConfigPkg::defaultOperandWidth;
	localparam int clockPeriod = 8;
	localparam int randomCases = 40;

	// signed range of one operand word, for the overflow rule
	localparam logic signed [2*operandWidth-1:0] hiLimit =
		{{(operandWidth + 1){1'b0}}, {(operandWidth - 1){1'b1}}};
	localparam logic signed [2*operandWidth-1:0] loLimit = ~hiLimit;

	logic clk;
	logic rstN;
	logic enable;
	logic mode;
	logic signed [operandWidth-1:0] a;
	logic signed [operandWidth-1:0] b;
	logic signed [2*operandWidth-1:0] product;
	logic overflow;
	logic busy;
	logic done;

	// directed vectors from the data file
	logic vecMode [$];
	logic signed [operandWidth-1:0] vecA [$];
	logic signed [operandWidth-1:0] vecB [$];
	logic signed [2*operandWidth-1:0] vecProduct [$];
	logic vecOverflow [$];

	int seed;
	int totalCases;
	logic casesKnown;

	boothMultiplier #(
		.operandWidth(operandWidth)
	) dut0 (
		.clk(clk),
		.rstN(rstN),
		.enable(enable),
		.mode(mode),
		.a(a),
		.b(b),
		.product(product),
		.overflow(overflow),
		.busy(busy),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(clockPeriod / 2);
			clk = ~clk;
		end
	end

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "stopping on the first error");
	endtask

	task automatic checkProduct(input string name, input logic signed [2*operandWidth-1:0] expected,
		input logic signed [2*operandWidth-1:0] actual);
		if (actual !== expected)
		begin
			reportFailure($sformatf("Fail %s product: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	task automatic checkOverflow(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			reportFailure($sformatf("Fail %s overflow: expected %b, actual %b",
				name, expected, actual));
		end
	endtask

	task automatic checkLatency(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			reportFailure($sformatf("Fail %s latency: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic loadVectors();
		int fd;
		int code;
		logic [8*128-1:0] headerLine;
		logic m;
		logic signed [operandWidth-1:0] va;
		logic signed [operandWidth-1:0] vb;
		logic signed [2*operandWidth-1:0] vp;
		logic vo;
		fd = $fopen("verif/mulInput.txt", "r");
		if (fd == 0)
		begin
			reportFailure("could not open verif/mulInput.txt");
		end
		// first line only names the columns
		code = $fgets(headerLine, fd);
		if (code == 0)
		begin
			reportFailure("could not read the first line of verif/mulInput.txt");
		end
		while ($fscanf(fd, "%h %h %h %h %h\n", m, va, vb, vp, vo) == 5)
		begin
			vecMode.push_back(m);
			vecA.push_back(va);
			vecB.push_back(vb);
			vecProduct.push_back(vp);
			vecOverflow.push_back(vo);
		end
		$fclose(fd);
		if (vecMode.size() == 0)
		begin
			reportFailure("no vectors were found in verif/mulInput.txt");
		end
	endtask

	// one multiply, optionally with a second start pulse while busy
	task automatic runMultiply(input string name, input logic m,
		input logic signed [operandWidth-1:0] opA, input logic signed [operandWidth-1:0] opB,
		input logic signed [2*operandWidth-1:0] expProduct, input logic expOverflow,
		input logic stray);
		int cycles;
		int expCycles;
		logic finished;
		expCycles = ((m == mulConfigPkg::modeRadix4) ? operandWidth / 2 : operandWidth) + 1;
		@(posedge clk);
		enable <= 1'b1;
		mode <= m;
		a <= opA;
		b <= opB;
		// the first edge in the loop takes the start and counts as zero
		cycles = -1;
		finished = 1'b0;
		while (!finished)
		begin
			@(posedge clk);
			enable <= stray && (cycles == 2);
			if (stray && cycles == 2)
			begin
				// what a second start would bring in
				mode <= ~m;
				a <= ~opA;
				b <= ~opB;
			end
			@(negedge clk);
			cycles++;
			finished = done;
			if (!finished && !busy)
			begin
				reportFailure($sformatf("busy went low before done in %s", name));
			end
		end
		checkLatency(name, expCycles, cycles);
		checkProduct(name, expProduct, product);
		checkOverflow(name, expOverflow, overflow);
	endtask

	initial
	begin
		logic signed [operandWidth-1:0] opA;
		logic signed [operandWidth-1:0] opB;
		logic signed [2*operandWidth-1:0] wideA;
		logic signed [2*operandWidth-1:0] wideB;
		logic signed [2*operandWidth-1:0] expProduct;
		logic expOverflow;
		logic randMode;
		rstN = 1'b0;
		enable = 1'b0;
		mode = 1'b0;
		a = '0;
		b = '0;
		seed = 32'h75b96a39;
		casesKnown = 1'b0;
		loadVectors();
		totalCases = vecMode.size() + randomCases;
		casesKnown = 1'b1;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		if (done || busy)
		begin
			reportFailure("done or busy is high after reset with no start");
		end
		checkProduct("after reset", '0, product);
		checkOverflow("after reset", 1'b0, overflow);
		foreach (vecMode[i])
		begin
			runMultiply($sformatf("vector %0d", i), vecMode[i], vecA[i], vecB[i],
				vecProduct[i], vecOverflow[i], 1'b0);
		end
		for (int i = 0; i < randomCases; i++)
		begin
			opA = $random(seed);
			opB = $random(seed);
			// odd cases use small operands so overflow stays low
			if (i % 2 == 1)
			begin
				opA = opA >>> (operandWidth / 2 + 4);
				opB = opB >>> (operandWidth / 2 + 4);
			end
			randMode = 1'($random(seed));
			wideA = (2 * operandWidth)'(opA);
			wideB = (2 * operandWidth)'(opB);
			expProduct = wideA * wideB;
			expOverflow = (expProduct > hiLimit) || (expProduct < loLimit);
			runMultiply($sformatf("random %0d", i), randMode, opA, opB,
				expProduct, expOverflow, 1'b1);
		end
		$display("Finished with no errors");
		$finish;
	end

	// watchdog sized from the number of cases
	initial
	begin
		wait (casesKnown);
		repeat (totalCases * (operandWidth + 4) + 50) @(posedge clk);
		reportFailure("watchdog timeout, the DUT did not finish all cases in time");
	end

endmodule

/* verif/mulInput.txt */
# columns in hex: mode (0 radix-2, 1 radix-4) a b product overflow
0 0000FF8D 0000E81F 00000000E7B6BA13 1
1 0000FF8D 0000E81F 00000000E7B6BA13 1
0 80000000 FFFFFFFF 0000000080000000 1
1 80000000 FFFFFFFF 0000000080000000 1
0 FFFFFFFD 00000005 FFFFFFFFFFFFFFF1 0
1 FFFFFFFD 00000005 FFFFFFFFFFFFFFF1 0
0 00000003 FFFFFFFB FFFFFFFFFFFFFFF1 0
1 00000003 FFFFFFFB FFFFFFFFFFFFFFF1 0
0 FFFFFFFD FFFFFFFB 000000000000000F 0
1 FFFFFFFD FFFFFFFB 000000000000000F 0
0 00000000 00003039 0000000000000000 0
1 00000000 00003039 0000000000000000 0
0 00000001 FFFFFFFF FFFFFFFFFFFFFFFF 0
1 00000001 FFFFFFFF FFFFFFFFFFFFFFFF 0
0 0000B505 0000B505 0000000080001219 1
1 0000B505 0000B505 0000000080001219 1
0 80000000 80000000 4000000000000000 1
1 80000000 80000000 4000000000000000 1
0 80000000 7FFFFFFF C000000080000000 1
1 80000000 7FFFFFFF C000000080000000 1

/* boothMultiplier.f */
src/mulConfigPkg.sv
src/boothPkg.sv
src/mulControl.sv
src/boothRecoder.sv
src/boothAccumulator.sv
src/resultRegister.sv
src/boothMultiplier.sv
verif/boothMultiplierTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 -f boothMultiplier.f --top-module boothMultiplierTb -o simBooth \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simBooth > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
